/* Makefile */
# Verilator build and run of the drive subsystem testbench

VERILATOR ?= verilator
TOP ?= tb_qdrv
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell cat $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_qdrv.sv */
// directed testbench for the qubit drive subsystem, checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_qdrv;

	localparam int ENV_AW = 10;
	localparam int CAR_AW = 8;
	localparam int ACC_W = 48;
	localparam int SHIFT = 4;
	localparam int TIMEOUT = 4000; // cycles allowed per wait loop
	localparam int LAT = 6; // strobe to drive sample: element 4, summer 2

	typedef struct packed {
		int e;
		int env_start;
		int len;
		int car_start;
		logic signed [15:0] amp;
		logic mode; // 1 for cw
		int t0; // cycle the ack was seen, strobe goes out with it
	} play_t;

	logic elem = 1'b0;
	logic rst_n;
	logic cmd_req;
	logic cmd_ack;
	logic [1:0] cmd_elem;
	logic [11:0] cmd_env_start;
	logic [11:0] cmd_env_len;
	logic [11:0] cmd_car_start;
	logic signed [15:0] cmd_amp;
	logic cmd_mode;
	logic wr_en;
	logic [1:0] wr_elem;
	logic wr_sel;
	logic [11:0] wr_addr;
	logic [31:0] wr_data;
	logic signed [15:0] adc_i;
	logic signed [15:0] adc_q;
	logic [4:0] shift;
	logic drv_valid;
	logic signed [15:0] drv_i;
	logic signed [15:0] drv_q;
	logic acc_stb;
	logic [31:0] acc_i;
	logic [31:0] acc_q;

	logic [31:0] rnd_state = 32'd21;
	int cyc = 0;
	logic signed [15:0] env_m [4][2**ENV_AW]; // copies of what was loaded
	logic [31:0] car_m [4][2**CAR_AW];
	play_t plays[$];
	int s_cyc[$]; // monitor capture, one entry per valid drive sample
	logic [31:0] s_iq[$];
	logic [31:0] s_adc[$];
	int exp_cyc[$];
	logic [31:0] exp_iq[$];
	int stb_cnt = 0;
	logic ack_prev = 1'b0;
	logic req_prev = 1'b0;

	always #50 elem = ~elem;

	always @(posedge elem) cyc <= cyc + 1;

	qdrv_top #(
		.ENV_AW(ENV_AW),
		.CAR_AW(CAR_AW),
		.ACC_W(ACC_W)
	) UUT (
		.elem(elem),
		.rst_n(rst_n),
		.cmd_req(cmd_req),
		.cmd_ack(cmd_ack),
		.cmd_elem(cmd_elem),
		.cmd_env_start(cmd_env_start),
		.cmd_env_len(cmd_env_len),
		.cmd_car_start(cmd_car_start),
		.cmd_amp(cmd_amp),
		.cmd_mode(cmd_mode),
		.wr_en(wr_en),
		.wr_elem(wr_elem),
		.wr_sel(wr_sel),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.adc_i(adc_i),
		.adc_q(adc_q),
		.shift(shift),
		.drv_valid(drv_valid),
		.drv_i(drv_i),
		.drv_q(drv_q),
		.acc_stb(acc_stb),
		.acc_i(acc_i),
		.acc_q(acc_q)
	);

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		report_error($sformatf("mismatch at %0t: %s got %0h expected %0h",
			$time, name, got, exp));
	endtask

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [15:0] next_rand();
		rnd_state = lcg(rnd_state);
		return rnd_state[31:16]; // high bits have the longer period
	endfunction

	// Q1.15 multiply, shifted down by 15 and cut to 16 bits
	function automatic logic signed [15:0] frac_mul(input logic signed [15:0] a,
			input logic signed [15:0] b);
		logic signed [31:0] p;
		p = a * b;
		p = p >>> 15;
		return p[15:0];
	endfunction

	// expected element output for sample k of a pulse, {i, q}
	function automatic logic [31:0] model_sample(input play_t p, input int k);
		logic signed [15:0] env;
		logic [31:0] car;
		logic signed [15:0] ei;
		logic signed [15:0] eq;
		if (p.mode) begin
			env = 16'sh7fff;
		end else begin
			env = env_m[p.e][(p.env_start + k) % (2**ENV_AW)];
		end
		car = car_m[p.e][(p.car_start + k) % (2**CAR_AW)]; // table wraps
		ei = frac_mul(env, car[31:16]);
		eq = frac_mul(env, car[15:0]);
		return {frac_mul(p.amp, ei), frac_mul(p.amp, eq)};
	endfunction

	function automatic play_t make_play(input int e, input int env_start, input int len,
			input int car_start, input int amp, input logic mode);
		play_t p;
		p.e = e;
		p.env_start = env_start;
		p.len = len;
		p.car_start = car_start;
		p.amp = 16'(amp);
		p.mode = mode;
		p.t0 = 0;
		return p;
	endfunction

	// capture of the drive stream and handshake rules, sampled mid-cycle
	always @(negedge elem) begin
		if (rst_n) begin
			assert (!(cmd_ack && !ack_prev && !req_prev))
				else report_error("cmd_ack rose without a pending request");
			assert (!(!cmd_ack && ack_prev && req_prev))
				else report_error("cmd_ack fell while the request was still high");
			if (drv_valid) begin
				s_cyc.push_back(cyc);
				s_iq.push_back({drv_i, drv_q});
				s_adc.push_back({adc_i, adc_q});
			end
			if (acc_stb) begin
				stb_cnt++;
			end
		end
		ack_prev = cmd_ack;
		req_prev = cmd_req;
	end

	task automatic load_elem(input int e);
		logic [15:0] hi;
		logic [15:0] lo;
		for (int a = 0; a < 2**ENV_AW; a++) begin
			hi = next_rand();
			lo = next_rand();
			@(posedge elem);
			wr_en <= 1'b1;
			wr_elem <= 2'(e);
			wr_sel <= 1'b0; // envelope
			wr_addr <= 12'(a);
			wr_data <= {hi, lo};
			env_m[e][a] = lo;
		end
		for (int a = 0; a < 2**CAR_AW; a++) begin
			hi = next_rand(); // cos
			lo = next_rand(); // sin
			@(posedge elem);
			wr_sel <= 1'b1;
			wr_addr <= 12'(a);
			wr_data <= {hi, lo};
			car_m[e][a] = {hi, lo};
		end
		@(posedge elem);
		wr_en <= 1'b0;
	endtask

	// full four-phase exchange, returns the cycles spent waiting for ack
	task automatic send_cmd(input play_t p, output int waited);
		int n;
		@(posedge elem);
		cmd_req <= 1'b1;
		cmd_elem <= 2'(p.e);
		cmd_env_start <= 12'(p.env_start);
		cmd_env_len <= 12'(p.len);
		cmd_car_start <= 12'(p.car_start);
		cmd_amp <= p.amp;
		cmd_mode <= p.mode;
		n = 0;
		do begin
			@(negedge elem);
			n++;
		end while (!cmd_ack && n < TIMEOUT);
		assert (cmd_ack) else report_error("no ack for a command within the timeout");
		waited = n;
		p.t0 = cyc;
		plays.push_back(p);
		@(posedge elem);
		cmd_req <= 1'b0;
		n = 0;
		do begin
			@(negedge elem);
			n++;
		end while (cmd_ack && n < TIMEOUT);
		assert (!cmd_ack) else report_error("cmd_ack stayed high after the request dropped");
	endtask

	task automatic start_test();
		@(posedge elem);
		plays.delete();
		s_cyc.delete();
		s_iq.delete();
		s_adc.delete();
		stb_cnt = 0;
	endtask

	// build the expected stream of all plays, wait for the last window, compare
	task automatic check_plays();
		int first;
		int last;
		int windows;
		int n;
		int k;
		logic active;
		logic [15:0] si;
		logic [15:0] sq;
		logic [31:0] v;
		exp_cyc.delete();
		exp_iq.delete();
		first = plays[0].t0 + LAT;
		last = first;
		foreach (plays[j]) begin
			if (plays[j].t0 + LAT < first) begin
				first = plays[j].t0 + LAT;
			end
			if (plays[j].t0 + LAT + plays[j].len - 1 > last) begin
				last = plays[j].t0 + LAT + plays[j].len - 1;
			end
		end
		windows = 0;
		for (int c = first; c <= last; c++) begin
			active = 1'b0;
			si = '0;
			sq = '0;
			foreach (plays[j]) begin
				k = c - plays[j].t0 - LAT;
				if (k >= 0 && k < plays[j].len) begin
					v = model_sample(plays[j], k);
					si = si + v[31:16]; // 16-bit wrap
					sq = sq + v[15:0];
					active = 1'b1;
				end
			end
			if (active) begin
				if (exp_cyc.size() == 0 || exp_cyc[$] != c - 1) begin
					windows++; // a gap opens a new window
				end
				exp_cyc.push_back(c);
				exp_iq.push_back({si, sq});
			end
		end
		n = 0;
		do begin
			@(posedge elem);
			n++;
		end while (stb_cnt < windows && n < TIMEOUT);
		assert (stb_cnt == windows) else report_mismatch("acc_stb count", stb_cnt, windows);
		assert (s_iq.size() == exp_iq.size())
			else report_mismatch("drv_valid length", s_iq.size(), exp_iq.size());
		foreach (exp_iq[j]) begin
			assert (s_cyc[j] == exp_cyc[j])
				else report_mismatch("drv_valid cycle", s_cyc[j], exp_cyc[j]);
			assert (s_iq[j][31:16] == exp_iq[j][31:16])
				else report_mismatch("drv_i", s_iq[j][31:16], exp_iq[j][31:16]);
			assert (s_iq[j][15:0] == exp_iq[j][15:0])
				else report_mismatch("drv_q", s_iq[j][15:0], exp_iq[j][15:0]);
		end
	endtask

	task automatic expect_idle_outputs();
		@(negedge elem);
		assert (!cmd_ack) else report_mismatch("cmd_ack", cmd_ack, 0);
		assert (!drv_valid) else report_mismatch("drv_valid", drv_valid, 0);
		assert (!acc_stb) else report_mismatch("acc_stb", acc_stb, 0);
	endtask

	// carrier start near the table end so the addresses wrap
	task automatic single_pulse_test();
		int waited;
		start_test();
		send_cmd(make_play(0, 100, 20, 250, 16'h6000, 1'b0), waited);
		check_plays();
	endtask

	task automatic handshake_test();
		int waited;
		start_test();
		// request sampled one cycle after it is raised, ack in the next
		send_cmd(make_play(2, 300, 24, 10, -20000, 1'b0), waited);
		assert (waited == 2) else report_mismatch("ack delay, idle element", waited, 2);
		// busy for cycles 1 to 24 after the strobe, request raised in cycle 3,
		// ack two cycles after busy ends, so in cycle 26
		send_cmd(make_play(2, 700, 12, 200, 12345, 1'b0), waited);
		assert (waited == 24) else report_mismatch("ack delay, busy element", waited, 24);
		check_plays();
	endtask

	task automatic cw_test();
		int waited;
		start_test();
		send_cmd(make_play(1, 0, 16, 30, 30000, 1'b1), waited);
		check_plays();
	endtask

	// overlapping windows, large amplitudes so the sums wrap
	task automatic sum_test();
		int waited;
		start_test();
		send_cmd(make_play(0, 40, 16, 0, 32767, 1'b0), waited);
		send_cmd(make_play(1, 520, 16, 64, -32768, 1'b0), waited);
		send_cmd(make_play(2, 900, 16, 128, 20000, 1'b0), waited);
		send_cmd(make_play(3, 1010, 16, 250, -9000, 1'b0), waited);
		check_plays();
	endtask

	task automatic demod_test();
		int waited;
		int n;
		longint si;
		longint sq;
		logic signed [15:0] ai;
		logic signed [15:0] aq;
		logic signed [15:0] li;
		logic signed [15:0] lq;
		start_test();
		fork
			send_cmd(make_play(3, 200, 32, 5, 28000, 1'b0), waited);
			begin
				n = 0;
				do begin
					@(posedge elem);
					adc_i <= next_rand();
					adc_q <= next_rand();
					n++;
				end while (stb_cnt == 0 && n < TIMEOUT);
			end
		join
		check_plays();
		si = 0;
		sq = 0;
		foreach (exp_iq[j]) begin
			ai = s_adc[j][31:16];
			aq = s_adc[j][15:0];
			li = exp_iq[j][31:16];
			lq = exp_iq[j][15:0];
			si = si + ai * li - aq * lq;
			sq = sq + ai * lq + aq * li;
		end
		si = si >>> SHIFT;
		sq = sq >>> SHIFT;
		repeat (8) @(posedge elem); // no second strobe may follow
		@(negedge elem);
		assert (stb_cnt == 1) else report_mismatch("acc_stb count", stb_cnt, 1);
		assert (acc_i == si[31:0]) else report_mismatch("acc_i", acc_i, si[31:0]);
		assert (acc_q == sq[31:0]) else report_mismatch("acc_q", acc_q, sq[31:0]);
	endtask

	// reset in the middle of a playing pulse
	task automatic reset_test();
		int waited;
		int n;
		start_test();
		send_cmd(make_play(0, 0, 40, 0, 10000, 1'b0), waited);
		n = 0;
		do begin
			@(negedge elem);
			n++;
		end while (!drv_valid && n < TIMEOUT);
		assert (drv_valid) else report_error("drive stream never started before reset");
		@(posedge elem);
		rst_n <= 1'b0;
		expect_idle_outputs();
		repeat (16) @(posedge elem);
		rst_n <= 1'b1;
		expect_idle_outputs();
	endtask

	initial begin
		rst_n = 1'b0;
		cmd_req = 1'b0;
		cmd_elem = '0;
		cmd_env_start = '0;
		cmd_env_len = '0;
		cmd_car_start = '0;
		cmd_amp = '0;
		cmd_mode = 1'b0;
		wr_en = 1'b0;
		wr_elem = '0;
		wr_sel = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		adc_i = '0;
		adc_q = '0;
		shift = 5'(SHIFT);
		repeat (16) @(posedge elem);
		rst_n <= 1'b1;
		expect_idle_outputs();
		for (int e = 0; e < 4; e++) begin
			load_elem(e);
		end
		single_pulse_test();
		handshake_test();
		cw_test();
		sum_test();
		demod_test();
		reset_test();
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/am_mod.sv */
// amplitude modulator: amp times envelope times complex carrier in two stages
`timescale 1ns/1ps
`default_nettype none

module am_mod (
	input logic elem,
	input logic rst_n,
	input logic gate_in,
	input dsp_pkg::sample_t env,
	input dsp_pkg::iq_t car,
	input dsp_pkg::sample_t amp,
	output logic gate_out,
	output dsp_pkg::iq_t iq
);
	logic gate_s1;
	dsp_pkg::iq_t env_car; // envelope times carrier

	// gate follows the data through both stages
	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			gate_s1 <= 1'b0;
			gate_out <= 1'b0;
		end else begin
			gate_s1 <= gate_in;
			gate_out <= gate_s1;
		end
	end

	always_ff @(posedge elem) begin
		env_car.i <= dsp_pkg::q15_mul(env, car.i); // env x cos
		env_car.q <= dsp_pkg::q15_mul(env, car.q); // env x sin
		// amp is held for the whole pulse, sampled here in stage 2
		iq.i <= dsp_pkg::q15_mul(amp, env_car.i);
		iq.q <= dsp_pkg::q15_mul(amp, env_car.q);
	end

endmodule

`default_nettype wire

/* logic/demod_acc.sv */
// demodulator: complex multiply of ADC by drive, accumulated over each gated window
`timescale 1ns/1ps
`default_nettype none

module demod_acc #(
	parameter int ACC_W = 48
) (
	input logic elem,
	input logic rst_n,
	input logic lo_valid,
	input dsp_pkg::iq_t lo,
	input dsp_pkg::iq_t adc,
	input logic [4:0] shift,
	output logic acc_stb,
	output logic [31:0] acc_i,
	output logic [31:0] acc_q
);
	dsp_pkg::sample_t adc_i_r;
	dsp_pkg::sample_t adc_q_r;
	dsp_pkg::sample_t lo_i_r;
	dsp_pkg::sample_t lo_q_r;
	logic signed [32:0] prod_i; // full precision, one bit of headroom
	logic signed [32:0] prod_q;
	logic signed [ACC_W-1:0] ext_i;
	logic signed [ACC_W-1:0] ext_q;
	logic signed [ACC_W-1:0] sum_i;
	logic signed [ACC_W-1:0] sum_q;
	logic gate_s1;
	logic gate_s2; // aligned with the product
	logic gate_s3;
	logic first;
	logic last;

	assign ext_i = ACC_W'(prod_i);
	assign ext_q = ACC_W'(prod_q);
	assign first = gate_s2 && !gate_s3; // window opens
	assign last = gate_s3 && !gate_s2; // window has closed

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			gate_s1 <= 1'b0;
			gate_s2 <= 1'b0;
			gate_s3 <= 1'b0;
			acc_stb <= 1'b0;
		end else begin
			gate_s1 <= lo_valid;
			gate_s2 <= gate_s1;
			gate_s3 <= gate_s2;
			acc_stb <= last;
		end
	end

	always_ff @(posedge elem) begin
		adc_i_r <= adc.i;
		adc_q_r <= adc.q;
		lo_i_r <= lo.i;
		lo_q_r <= lo.q;
		prod_i <= adc_i_r * lo_i_r - adc_q_r * lo_q_r;
		prod_q <= adc_i_r * lo_q_r + adc_q_r * lo_i_r;
		if (gate_s2) begin
			sum_i <= first ? ext_i : sum_i + ext_i;
			sum_q <= first ? ext_q : sum_q + ext_q;
		end
		if (last) begin
			acc_i <= 32'(sum_i >>> shift); // held until the next window
			acc_q <= 32'(sum_q >>> shift);
		end
	end

	a_shift: assert property (@(posedge elem) disable iff (!rst_n)
		last |-> (shift < 5'd17))
		else $error("demod_acc: shift out of range at window close");

endmodule

`default_nettype wire

/* logic/dsp_pkg.sv */
// datapath definitions: samples, I/Q pairs and Q1.15 arithmetic
`default_nettype none

package dsp_pkg;

	typedef logic signed [15:0] sample_t;

	// carrier tables use the same layout, cos in i and sin in q
	typedef struct packed {
		sample_t i;
		sample_t q;
	} iq_t;

	localparam sample_t FULL_SCALE = 16'h7fff; // envelope in cw mode
	localparam int FRAC = 15; // fraction bits of a Q1.15 value

	// Q1.15 product shifted back down and truncated to a sample
	function automatic sample_t q15_mul(input sample_t a, input sample_t b);
		logic signed [31:0] p;
		p = a * b;
		return sample_t'(p >>> FRAC);
	endfunction

endpackage

`default_nettype wire

/* logic/elem_cmd.sv */
// four-phase command receiver that routes each command to the addressed element
`timescale 1ns/1ps
`default_nettype none

module elem_cmd (
	input logic elem,
	input logic rst_n,
	input logic cmd_req,
	output logic cmd_ack,
	input logic [1:0] cmd_elem,
	input elem_pkg::elem_cmd_t cmd,
	elem_if.ctl ctl [elem_pkg::N_ELEM]
);
	elem_pkg::cmd_state_e state;
	elem_pkg::elem_cmd_t cmd_r; // command held for the strobe
	logic [1:0] sel_r; // addressed element
	logic stb_r;
	logic [elem_pkg::N_ELEM-1:0] busy_v;
	logic [elem_pkg::N_ELEM-1:0] stb_v;

	for (genvar g = 0; g < elem_pkg::N_ELEM; g++) begin : g_route
		assign busy_v[g] = ctl[g].busy;
		assign stb_v[g] = stb_r && (sel_r == g);
		assign ctl[g].cmdstb = stb_v[g];
		assign ctl[g].cmd = cmd_r; // word is broadcast, strobe selects
	end

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			state <= elem_pkg::IDLE;
			stb_r <= 1'b0;
			cmd_ack <= 1'b0;
			sel_r <= '0;
		end else begin
			stb_r <= 1'b0;
			case (state)
				elem_pkg::IDLE: begin
					if (cmd_req) begin
						sel_r <= cmd_elem;
						if (busy_v[cmd_elem]) begin
							state <= elem_pkg::WAIT_FREE; // hold off the ack
						end else begin
							stb_r <= 1'b1;
							cmd_ack <= 1'b1;
							state <= elem_pkg::ACK;
						end
					end
				end
				elem_pkg::WAIT_FREE: begin
					if (!busy_v[sel_r]) begin
						stb_r <= 1'b1;
						cmd_ack <= 1'b1;
						state <= elem_pkg::ACK;
					end
				end
				elem_pkg::ACK: begin
					if (!cmd_req) begin
						cmd_ack <= 1'b0; // fourth phase
						state <= elem_pkg::IDLE;
					end
				end
				default: state <= elem_pkg::IDLE;
			endcase
		end
	end

	// fields are stable while the request is up, take them as it arrives
	always_ff @(posedge elem) begin
		if (state == elem_pkg::IDLE && cmd_req) begin
			cmd_r <= cmd;
		end
	end

	a_ack_req: assert property (@(posedge elem) disable iff (!rst_n)
		$rose(cmd_ack) |-> $past(cmd_req))
		else $error("elem_cmd: ack raised without a request");

	// one strobe, to the element still named by the request, with its fields unchanged
	a_one_stb: assert property (@(posedge elem) disable iff (!rst_n)
		(|stb_v) |-> ($onehot(stb_v) && stb_v[cmd_elem] && cmd_r == cmd))
		else $error("elem_cmd: strobe to several or the wrong element, or with a stale command");

endmodule

`default_nettype wire

/* logic/elem_gen.sv */
// pulse element: address sequencer over envelope and carrier memories feeding the modulator
`timescale 1ns/1ps
`default_nettype none

module elem_gen #(
	parameter int ENV_AW = 10,
	parameter int CAR_AW = 8
) (
	input logic elem,
	input logic rst_n,
	elem_if.gen gen,
	input logic wr_env,
	input logic wr_car,
	input logic [elem_pkg::ADDR_W-1:0] wr_addr,
	input logic [31:0] wr_data
);
	logic [ENV_AW-1:0] env_addr;
	logic [CAR_AW-1:0] car_addr; // wraps modulo table size
	logic [elem_pkg::ADDR_W-1:0] left; // samples still to issue
	logic busy;
	logic gate_rd; // busy delayed by the memory read
	logic cw_r;
	dsp_pkg::sample_t amp_r;
	logic [15:0] env_rd;
	dsp_pkg::iq_t car_rd;
	dsp_pkg::sample_t env_mix;

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			gate_rd <= 1'b0;
			left <= '0;
		end else begin
			gate_rd <= busy;
			if (gen.cmdstb) begin
				busy <= 1'b1;
				left <= gen.cmd.env_len;
			end else if (busy) begin
				left <= left - 1'b1;
				if (left == elem_pkg::ADDR_W'(1)) begin
					busy <= 1'b0; // last address goes out this cycle
				end
			end
		end
	end

	always_ff @(posedge elem) begin
		if (gen.cmdstb) begin
			env_addr <= gen.cmd.env_start[ENV_AW-1:0];
			car_addr <= gen.cmd.car_start[CAR_AW-1:0];
			amp_r <= gen.cmd.amp;
			cw_r <= (gen.cmd.mode == elem_pkg::MODE_CW);
		end else if (busy) begin
			env_addr <= env_addr + 1'b1;
			car_addr <= car_addr + 1'b1;
		end
	end

	assign env_mix = cw_r ? dsp_pkg::FULL_SCALE : dsp_pkg::sample_t'(env_rd);
	assign gen.busy = busy;

	wave_mem #(
		.AW(ENV_AW),
		.DW(16)
	) u_env (
		.elem(elem),
		.we(wr_env),
		.waddr(wr_addr[ENV_AW-1:0]),
		.wdata(wr_data[15:0]), // envelope uses the low half
		.raddr(env_addr),
		.rdata(env_rd)
	);

	wave_mem #(
		.AW(CAR_AW),
		.DW(32)
	) u_car (
		.elem(elem),
		.we(wr_car),
		.waddr(wr_addr[CAR_AW-1:0]),
		.wdata(wr_data),
		.raddr(car_addr),
		.rdata(car_rd)
	);

	am_mod u_mod (
		.elem(elem),
		.rst_n(rst_n),
		.gate_in(gate_rd),
		.env(env_mix),
		.car(car_rd),
		.amp(amp_r),
		.gate_out(gen.valid),
		.iq(gen.iq)
	);

	a_len_nz: assert property (@(posedge elem) disable iff (!rst_n)
		gen.cmdstb |-> (gen.cmd.env_len != '0))
		else $error("elem_gen: command with zero envelope length");

endmodule

`default_nettype wire

/* logic/elem_if.sv */
// per-element bundle carrying command strobe and word, busy status and the output stream
`timescale 1ns/1ps
`default_nettype none

interface elem_if (
	input logic elem
);
	logic cmdstb; // one-cycle command strobe
	elem_pkg::elem_cmd_t cmd;
	logic busy; // addresses still being issued
	logic valid;
	dsp_pkg::iq_t iq;

	// command side
	modport ctl (
		output cmdstb,
		output cmd,
		input busy
	);

	// element generator side
	modport gen (
		input cmdstb,
		input cmd,
		output busy,
		output valid,
		output iq
	);

	// summer side, stream only
	modport out (
		input valid,
		input iq
	);

	// receiver and generator agree that a playing element is never restarted
	a_stb_idle: assert property (@(posedge elem) cmdstb |-> !busy)
		else $error("elem_if: command strobe while element busy");

endinterface

`default_nettype wire

/* logic/elem_pkg.sv */
// control definitions for the drive elements: command layout, modes and receiver states
`default_nettype none

package elem_pkg;

	localparam int N_ELEM = 4; // fixed by the four-input summer
	localparam int ADDR_W = 12; // address field width carried in a command

	typedef enum logic {
		MODE_PULSE = 1'b0, // envelope read from memory
		MODE_CW = 1'b1 // envelope held at full scale
	} elem_mode_e;

	// 53-bit command word as handed over by the sequencer
	typedef struct packed {
		logic [ADDR_W-1:0] env_start;
		logic [ADDR_W-1:0] env_len; // samples to play
		logic [ADDR_W-1:0] car_start;
		logic signed [15:0] amp;
		elem_mode_e mode;
	} elem_cmd_t;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_FREE, // addressed element still playing
		ACK
	} cmd_state_e;

endpackage

`default_nettype wire

/* logic/elem_sum4.sv */
// two-stage adder tree merging the four element streams into one drive stream
`timescale 1ns/1ps
`default_nettype none

module elem_sum4 (
	input logic elem,
	input logic rst_n,
	elem_if.out e0,
	elem_if.out e1,
	elem_if.out e2,
	elem_if.out e3,
	output logic valid,
	output dsp_pkg::iq_t iq
);
	dsp_pkg::iq_t in0;
	dsp_pkg::iq_t in1;
	dsp_pkg::iq_t in2;
	dsp_pkg::iq_t in3;
	dsp_pkg::iq_t sum01;
	dsp_pkg::iq_t sum23;
	logic any_v;

	// an idle element contributes nothing
	assign in0 = e0.valid ? e0.iq : '0;
	assign in1 = e1.valid ? e1.iq : '0;
	assign in2 = e2.valid ? e2.iq : '0;
	assign in3 = e3.valid ? e3.iq : '0;

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			any_v <= 1'b0;
			valid <= 1'b0;
		end else begin
			any_v <= e0.valid | e1.valid | e2.valid | e3.valid;
			valid <= any_v;
		end
	end

	// sums wrap at 16 bits
	always_ff @(posedge elem) begin
		sum01.i <= in0.i + in1.i;
		sum01.q <= in0.q + in1.q;
		sum23.i <= in2.i + in3.i;
		sum23.q <= in2.q + in3.q;
		iq.i <= sum01.i + sum23.i;
		iq.q <= sum01.q + sum23.q;
	end

endmodule

`default_nettype wire

/* logic/qdrv_top.sv */
// qubit drive subsystem: command receiver, four pulse elements, summer and demodulator
`timescale 1ns/1ps
`default_nettype none

module qdrv_top #(
	parameter int ENV_AW = 10,
	parameter int CAR_AW = 8,
	parameter int ACC_W = 48
) (
	input logic elem,
	input logic rst_n,
	input logic cmd_req,
	output logic cmd_ack,
	input logic [1:0] cmd_elem,
	input logic [elem_pkg::ADDR_W-1:0] cmd_env_start,
	input logic [elem_pkg::ADDR_W-1:0] cmd_env_len,
	input logic [elem_pkg::ADDR_W-1:0] cmd_car_start,
	input logic signed [15:0] cmd_amp,
	input logic cmd_mode, // 0 pulse, 1 cw
	input logic wr_en,
	input logic [1:0] wr_elem,
	input logic wr_sel, // 0 envelope, 1 carrier
	input logic [elem_pkg::ADDR_W-1:0] wr_addr,
	input logic [31:0] wr_data,
	input logic signed [15:0] adc_i,
	input logic signed [15:0] adc_q,
	input logic [4:0] shift,
	output logic drv_valid,
	output logic signed [15:0] drv_i,
	output logic signed [15:0] drv_q,
	output logic acc_stb,
	output logic [31:0] acc_i,
	output logic [31:0] acc_q
);
	elem_pkg::elem_cmd_t cmd;
	dsp_pkg::iq_t adc;
	dsp_pkg::iq_t drv;
	logic [elem_pkg::N_ELEM-1:0] wr_env;
	logic [elem_pkg::N_ELEM-1:0] wr_car;

	assign cmd = '{
		env_start: cmd_env_start,
		env_len: cmd_env_len,
		car_start: cmd_car_start,
		amp: cmd_amp,
		mode: elem_pkg::elem_mode_e'(cmd_mode)
	};
	assign adc = '{i: adc_i, q: adc_q};
	assign drv_i = drv.i;
	assign drv_q = drv.q;

	elem_if ei [elem_pkg::N_ELEM] (.elem(elem));

	elem_cmd u_cmd (
		.elem(elem),
		.rst_n(rst_n),
		.cmd_req(cmd_req),
		.cmd_ack(cmd_ack),
		.cmd_elem(cmd_elem),
		.cmd(cmd),
		.ctl(ei)
	);

	for (genvar g = 0; g < elem_pkg::N_ELEM; g++) begin : g_elem
		assign wr_env[g] = wr_en && !wr_sel && (wr_elem == g);
		assign wr_car[g] = wr_en && wr_sel && (wr_elem == g);

		elem_gen #(
			.ENV_AW(ENV_AW),
			.CAR_AW(CAR_AW)
		) u_gen (
			.elem(elem),
			.rst_n(rst_n),
			.gen(ei[g]),
			.wr_env(wr_env[g]),
			.wr_car(wr_car[g]),
			.wr_addr(wr_addr),
			.wr_data(wr_data)
		);
	end

	elem_sum4 u_sum (
		.elem(elem),
		.rst_n(rst_n),
		.e0(ei[0]),
		.e1(ei[1]),
		.e2(ei[2]),
		.e3(ei[3]),
		.valid(drv_valid),
		.iq(drv)
	);

	demod_acc #(
		.ACC_W(ACC_W)
	) u_acc (
		.elem(elem),
		.rst_n(rst_n),
		.lo_valid(drv_valid),
		.lo(drv),
		.adc(adc),
		.shift(shift),
		.acc_stb(acc_stb),
		.acc_i(acc_i),
		.acc_q(acc_q)
	);

endmodule

`default_nettype wire

/* logic/wave_mem.sv */
// waveform memory with a synchronous write port and a registered read
`timescale 1ns/1ps
`default_nettype none

module wave_mem #(
	parameter int AW = 10,
	parameter int DW = 16
) (
	input logic elem,
	input logic we,
	input logic [AW-1:0] waddr,
	input logic [DW-1:0] wdata,
	input logic [AW-1:0] raddr,
	output logic [DW-1:0] rdata
);
	logic [DW-1:0] mem [2**AW];

	always_ff @(posedge elem) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr]; // one cycle read latency
	end

endmodule

`default_nettype wire

/* tb.f */
logic/elem_pkg.sv
logic/dsp_pkg.sv
logic/elem_if.sv
logic/elem_cmd.sv
logic/wave_mem.sv
logic/am_mod.sv
logic/elem_gen.sv
logic/elem_sum4.sv
logic/demod_acc.sv
logic/qdrv_top.sv
bench/tb_qdrv.sv
